/* files.f */
+incdir+testbench
hdl/pers_dispatch_pkg.sv
hdl/pers_mem_pkg.sv
hdl/inst_decoder.sv
hdl/aeg_file.sv
hdl/dispatch_ctrl.sv
hdl/sweep_engine.sv
hdl/pers_top.sv
testbench/tb_pers_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= tb_pers_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Result: PASSED

SRCS := $(shell grep -v '^+' $(FILELIST)) testbench/tb_pers_tasks.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_pers_tasks.svh */
// --------------------------------------------------
// Instruction builders
// --------------------------------------------------
function automatic inst_t f4_inst(input logic [6:0] opc, input logic [11:0] imm);
   logic [31:0] w;
   w = {3'b000, 4'b1101, opc, imm, 6'h00};
   return w;
endfunction

function automatic inst_t f567_inst(input logic [4:0] fmt, input logic [5:0] opc,
                                    input logic [5:0] hi, input logic [5:0] mid,
                                    input logic [5:0] lo);
   logic [31:0] w;
   w = {3'b000, fmt, opc, hi, mid, lo};
   return w;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_word(input string msg, input aeg_word_t got, input aeg_word_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s got %h expected %h", $time, msg, got, exp);
   end
endtask

task automatic check_exc(input string msg, input exc_t got, input exc_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s exception %b expected %b", $time, msg, got, exp);
   end
endtask

task automatic check_addr(input string msg, input vadr_t got, input vadr_t exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s address %h expected %h", $time, msg, got, exp);
   end
endtask

task automatic check_flag(input string msg, input logic got, input logic exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s is %b expected %b", $time, msg, got, exp);
   end
endtask

task automatic check_count(input string msg, input int got, input int exp);
   chk_cnt++;
   if (got != exp) begin
      err_cnt++;
      $display("** Error @ %0t: %s count %0d expected %0d", $time, msg, got, exp);
   end
endtask

task automatic test_done(input string name, input int err_before);
   test_cnt++;
   if (err_cnt == err_before)
      $display("Test %s: ok", name);
   else
      $display("Test %s: %0d errors", name, err_cnt - err_before);
endtask

// --------------------------------------------------
// Instruction issue right after a rising edge
// --------------------------------------------------
task automatic issue(input inst_t inst, input aeg_word_t data,
                     output exc_t exc, output logic stl);
   inst_i     <= inst;
   data_i     <= data;
   inst_vld_i <= 1'b1;
   @(negedge clk_per);
   exc = exception_o;
   stl = stall_o;
   @(posedge clk_per);
   inst_vld_i <= 1'b0;
endtask

task automatic write_aeg(input string msg, input inst_t inst, input aeg_word_t data,
                         input exc_t exp_exc);
   exc_t exc;
   logic stl;
   issue(inst, data, exc, stl);
   check_exc(msg, exc, exp_exc);
   check_flag({msg, " stall"}, stl, 1'b0);
endtask

// Return valid only in the cycle after edge N+2
task automatic read_check(input string msg, input inst_t inst, input aeg_word_t data,
                          input aeg_word_t exp, input exc_t exp_exc);
   exc_t exc;
   logic stl;
   issue(inst, data, exc, stl);
   check_exc(msg, exc, exp_exc);
   check_flag({msg, " stall"}, stl, 1'b0);
   @(negedge clk_per);
   check_flag({msg, " early valid"}, ret_data_vld_o, 1'b0);
   @(negedge clk_per);
   check_flag({msg, " valid"}, ret_data_vld_o, 1'b1);
   check_word(msg, ret_data_o, exp);
   @(negedge clk_per);
   check_flag({msg, " late valid"}, ret_data_vld_o, 1'b0);
   @(posedge clk_per);
endtask

task automatic no_return(input string msg, input inst_t inst, input exc_t exp_exc);
   exc_t exc;
   logic stl;
   issue(inst, '0, exc, stl);
   check_exc(msg, exc, exp_exc);
   check_flag({msg, " stall"}, stl, 1'b0);
   repeat (3) begin
      @(negedge clk_per);
      check_flag({msg, " return valid"}, ret_data_vld_o, 1'b0);
   end
   @(posedge clk_per);
endtask

// --------------------------------------------------
// Directed tests
// --------------------------------------------------
task automatic test_aeg_access();
   int e0;
   e0 = err_cnt;
   write_aeg("f5 wr a", f567_inst(5'b11100, OP_F5_WR_A, 6'h0, 6'h0, 6'h0),
             64'h0123_4567_89AB_CDEF, 2'b00);
   read_check("f4 rd data 0", f4_inst(OP_F4_RD_DATA, 12'h0), 64'h0,
              64'h0123_4567_89AB_CDEF, 2'b00);
   write_aeg("f5 wr b", f567_inst(5'b11100, OP_F5_WR_B, 6'h0, 6'h0, 6'h2),
             64'hFEDC_BA98_7654_3210, 2'b00);
   read_check("f6 rd imm 2", f567_inst(5'b11101, OP_F6_RD_IMM, 6'h0, 6'h2, 6'h0), 64'h0,
              64'hFEDC_BA98_7654_3210, 2'b00);
   // Index comes from the low data bits, so the value carries it
   write_aeg("f4 wr data", f4_inst(OP_F4_WR_DATA, 12'h0), 64'h5A5A_0000_0000_0001, 2'b00);
   read_check("f4 rd imm 1", f4_inst(OP_F4_RD_IMM, 12'h1), 64'h0,
              64'h5A5A_0000_0000_0001, 2'b00);
   read_check("f4 rd imm 0", f4_inst(OP_F4_RD_IMM, 12'h0), 64'h0,
              64'h0123_4567_89AB_CDEF, 2'b00);
   test_done("aeg_access", e0);
endtask

task automatic test_idx_range();
   int e0;
   e0 = err_cnt;
   read_check("rd idx 3", f567_inst(5'b11101, OP_F6_RD_IMM, 6'h0, 6'h3, 6'h0), 64'h0,
              64'h0, 2'b00);
   read_check("rd idx 200", f4_inst(OP_F4_RD_IMM, 12'd200), 64'h0, 64'h0, 2'b00);
   read_check("rd idx 255", f4_inst(OP_F4_RD_DATA, 12'h0), 64'd255, 64'h0, 2'b00);
   read_check("rd idx 256", f4_inst(OP_F4_RD_IMM, 12'd256), 64'h0, 64'h0, 2'b10);
   read_check("rd idx 3ffff", f4_inst(OP_F4_RD_DATA, 12'h0), 64'h3FFFF, 64'h0, 2'b10);
   write_aeg("wr idx fff", f567_inst(5'b11100, OP_F5_WR_A, 6'h3F, 6'h0, 6'h3F),
             64'h1, 2'b10);
   test_done("idx_range", e0);
endtask

task automatic test_unimpl();
   int e0;
   e0 = err_cnt;
   no_return("bad f4 opcode", f4_inst(7'h41, 12'h0), 2'b01);
   no_return("bad f5 opcode", f567_inst(5'b11100, 6'h01, 6'h0, 6'h0, 6'h0), 2'b01);
   no_return("bad format", f567_inst(5'b00000, 6'h0, 6'h0, 6'h0, 6'h0), 2'b01);
   no_return("f7 bit 23 clear", f567_inst(5'b11110, 6'h00, 6'h0, 6'h0, 6'h0), 2'b01);
   test_done("unimpl", e0);
endtask

task automatic run_kernel(input string name, input vadr_t base, input int threads,
                          input int edges, input int pct);
   int        e0;
   int        cyc;
   int        eff;
   exc_t      exc;
   logic      stl;
   aeg_word_t exp_sum;
   e0 = err_cnt;
   write_aeg("set base", f567_inst(5'b11100, OP_F5_WR_A, 6'h0, 6'h0, 6'h0),
             aeg_word_t'(base), 2'b00);
   write_aeg("set threads", f567_inst(5'b11100, OP_F5_WR_B, 6'h0, 6'h0, 6'h1),
             aeg_word_t'(threads), 2'b00);
   write_aeg("set edges", f567_inst(5'b11100, OP_F5_WR_A, 6'h0, 6'h0, 6'h2),
             aeg_word_t'(edges), 2'b00);
   stall_pct = pct;
   ld_addrs.delete();
   st_cnt       = 0;
   max_inflight = 0;
   intlv_dis_i <= 1'b1;
   issue(f567_inst(5'b11110, 6'h20, 6'h0, 6'h0, 6'h0), '0, exc, stl);
   check_exc("caep00", exc, 2'b00);
   check_flag("stall in start cycle", stl, 1'b1);
   // Stall must hold until the store is taken
   cyc = 0;
   while (st_cnt == 0) begin
      @(negedge clk_per);
      if (st_cnt == 0)
         check_flag("stall during run", stall_o, 1'b1);
      cyc++;
      if (cyc > 5000)
         timeout_fail("kernel store never arrived");
   end
   cyc = 0;
   while (!(idle_o && !stall_o)) begin
      @(negedge clk_per);
      cyc++;
      if (cyc > 100)
         timeout_fail("kernel did not return to idle");
   end
   stall_pct = 0;
   eff = (threads == 0) ? 1 : threads;
   exp_sum = '0;
   for (int i = 0; i < edges; i++)
      exp_sum = exp_sum + (aeg_word_t'(base + vadr_t'(8 * i)) * 3 + 1);
   check_count("loads", ld_addrs.size(), edges);
   for (int i = 0; i < ld_addrs.size(); i++)
      check_addr("load", ld_addrs[i], base + vadr_t'(8 * i));
   check_count("stores", st_cnt, 1);
   check_addr("store", st_addr, base + vadr_t'(8 * edges));
   check_word("sum", aeg_word_t'(st_data), exp_sum);
   check_flag("in flight limit", max_inflight <= eff, 1'b1);
   @(posedge clk_per);
   test_done(name, e0);
endtask

task automatic test_no_start();
   int   e0;
   exc_t exc;
   logic stl;
   e0 = err_cnt;
   ld_addrs.delete();
   st_cnt = 0;
   intlv_dis_i <= 1'b0;
   issue(f567_inst(5'b11110, 6'h20, 6'h0, 6'h0, 6'h0), '0, exc, stl);
   check_exc("caep00 intlv low", exc, 2'b00);
   check_flag("caep00 intlv low stall", stl, 1'b0);
   intlv_dis_i <= 1'b1;
   issue(f567_inst(5'b11110, 6'h25, 6'h0, 6'h0, 6'h0), '0, exc, stl);
   check_exc("caep05", exc, 2'b00);
   check_flag("caep05 stall", stl, 1'b0);
   repeat (8) begin
      @(negedge clk_per);
      check_flag("stall after caep", stall_o, 1'b0);
   end
   check_count("requests", ld_addrs.size() + st_cnt, 0);
   @(posedge clk_per);
   test_done("no_start", e0);
endtask

/* testbench/tb_pers_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pers_top;

   import pers_dispatch_pkg::*;
   import pers_mem_pkg::*;

   logic      clk_per;
   logic      reset_per;
   inst_t     inst_i;
   aeg_word_t data_i;
   logic      inst_vld_i;
   logic      intlv_dis_i;
   logic      mc_rd_rq_stall_i;
   logic      mc_wr_rq_stall_i;
   logic      mc_rsp_push_i;
   mem_word_t mc_rsp_data_i;
   aeg_word_t ret_data_o;
   logic      ret_data_vld_o;
   exc_t      exception_o;
   logic      stall_o;
   logic      idle_o;
   logic      mc_req_ld_o;
   logic      mc_req_st_o;
   vadr_t     mc_req_vadr_o;
   mem_word_t mc_req_wrd_o;

   // Memory model state, shared with the test tasks
   integer    seed = 32660;
   int        stall_pct;
   int        rsp_pct;
   vadr_t     pending[$];
   vadr_t     ld_addrs[$];
   int        st_cnt;
   vadr_t     st_addr;
   mem_word_t st_data;
   int        inflight;
   int        max_inflight;
   int        pick;

   int        err_cnt;
   int        chk_cnt;
   int        test_cnt;

   pers_top #(
      .AEG_COUNT (3)
   ) dut0 (
      .clk_per          (clk_per),
      .reset_per        (reset_per),
      .inst_i           (inst_i),
      .data_i           (data_i),
      .inst_vld_i       (inst_vld_i),
      .intlv_dis_i      (intlv_dis_i),
      .mc_rd_rq_stall_i (mc_rd_rq_stall_i),
      .mc_wr_rq_stall_i (mc_wr_rq_stall_i),
      .mc_rsp_push_i    (mc_rsp_push_i),
      .mc_rsp_data_i    (mc_rsp_data_i),
      .ret_data_o       (ret_data_o),
      .ret_data_vld_o   (ret_data_vld_o),
      .exception_o      (exception_o),
      .stall_o          (stall_o),
      .idle_o           (idle_o),
      .mc_req_ld_o      (mc_req_ld_o),
      .mc_req_st_o      (mc_req_st_o),
      .mc_req_vadr_o    (mc_req_vadr_o),
      .mc_req_wrd_o     (mc_req_wrd_o)
   );

   always #10 clk_per = ~clk_per;

   // --------------------------------------------------
   // Memory model
   // --------------------------------------------------
   always @(posedge clk_per) begin
      if (mc_req_ld_o) begin
         ld_addrs.push_back(mc_req_vadr_o);
         pending.push_back(mc_req_vadr_o);
      end
      if (mc_req_st_o) begin
         st_cnt  = st_cnt + 1;
         st_addr = mc_req_vadr_o;
         st_data = mc_req_wrd_o;
      end
      if (mc_req_ld_o || mc_rsp_push_i) begin
         inflight = inflight + int'(mc_req_ld_o) - int'(mc_rsp_push_i);
         if (inflight > max_inflight)
            max_inflight = inflight;
      end
      mc_rd_rq_stall_i <= ($unsigned($random(seed)) % 100) < stall_pct;
      mc_wr_rq_stall_i <= ($unsigned($random(seed)) % 100) < stall_pct;
      mc_rsp_push_i    <= 1'b0;
      // Answer any pending load, in random order
      if (pending.size() > 0 && ($unsigned($random(seed)) % 100) < rsp_pct) begin
         pick = $unsigned($random(seed)) % pending.size();
         mc_rsp_push_i <= 1'b1;
         mc_rsp_data_i <= mem_word_t'(pending[pick]) * 3 + 1;
         pending.delete(pick);
      end
   end

   task automatic timeout_fail(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("Result: FAILED");
      $finish;
   endtask

   `include "tb_pers_tasks.svh"

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      clk_per          = 1'b0;
      reset_per        <= 1'b1;
      inst_i           <= '0;
      data_i           <= '0;
      inst_vld_i       <= 1'b0;
      intlv_dis_i      <= 1'b0;
      mc_rd_rq_stall_i <= 1'b0;
      mc_wr_rq_stall_i <= 1'b0;
      mc_rsp_push_i    <= 1'b0;
      mc_rsp_data_i    <= '0;
      stall_pct    = 0;
      rsp_pct      = 50;
      st_cnt       = 0;
      inflight     = 0;
      max_inflight = 0;
      err_cnt      = 0;
      chk_cnt      = 0;
      test_cnt     = 0;
      repeat (10) @(posedge clk_per);
      reset_per <= 1'b0;
      @(posedge clk_per);

      test_aeg_access();
      test_idx_range();
      test_unimpl();
      run_kernel("kernel_basic", 48'h1000, 2, 10, 0);
      run_kernel("kernel_stall_t1", 48'h2_0040, 1, 16, 70);
      run_kernel("kernel_stall_t4", 48'h3_0800, 4, 16, 70);
      run_kernel("kernel_zero_edges", 48'h4000, 4, 0, 30);
      test_no_start();

      $display("Tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/pers_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pers_top #(
   parameter int AEG_COUNT = 3
) (
   input  wire                               clk_per,
   input  wire                               reset_per,
   input  wire pers_dispatch_pkg::inst_t     inst_i,
   input  wire pers_dispatch_pkg::aeg_word_t data_i,
   input  wire                               inst_vld_i,
   input  wire                               intlv_dis_i,
   input  wire                               mc_rd_rq_stall_i,
   input  wire                               mc_wr_rq_stall_i,
   input  wire                               mc_rsp_push_i,
   input  wire pers_mem_pkg::mem_word_t      mc_rsp_data_i,
   output pers_dispatch_pkg::aeg_word_t      ret_data_o,
   output logic                              ret_data_vld_o,
   output pers_dispatch_pkg::exc_t           exception_o,
   output logic                              stall_o,
   output logic                              idle_o,
   output logic                              mc_req_ld_o,
   output logic                              mc_req_st_o,
   output pers_mem_pkg::vadr_t               mc_req_vadr_o,
   output pers_mem_pkg::mem_word_t           mc_req_wrd_o
);

   import pers_dispatch_pkg::*;
   import pers_mem_pkg::*;

   logic        dec_wren;
   logic        dec_rden;
   aeg_idx_t    dec_idx;
   logic        start_req;
   logic        rd_vld;
   vadr_t       base_addr;
   thread_cnt_t num_threads;
   edge_cnt_t   edge_count;
   logic        start;
   logic        engine_idle;

   // --------------------------------------------------
   // Dispatch path
   // --------------------------------------------------
   inst_decoder u_dec (
      .inst_i      (inst_i),
      .data_i      (data_i),
      .inst_vld_i  (inst_vld_i),
      .intlv_dis_i (intlv_dis_i),
      .aeg_wren_o  (dec_wren),
      .aeg_rden_o  (dec_rden),
      .aeg_idx_o   (dec_idx),
      .start_req_o (start_req),
      .exception_o (exception_o)
   );

   aeg_file #(
      .AEG_COUNT (AEG_COUNT)
   ) u_aeg (
      .clk_per       (clk_per),
      .reset_per     (reset_per),
      .aeg_wren_i    (dec_wren),
      .aeg_rden_i    (dec_rden),
      .aeg_idx_i     (dec_idx),
      .data_i        (data_i),
      .ret_data_o    (ret_data_o),
      .rd_vld_o      (rd_vld),
      .base_addr_o   (base_addr),
      .num_threads_o (num_threads),
      .edge_count_o  (edge_count)
   );

   dispatch_ctrl u_ctrl (
      .clk_per        (clk_per),
      .reset_per      (reset_per),
      .start_req_i    (start_req),
      .engine_idle_i  (engine_idle),
      .rd_vld_i       (rd_vld),
      .start_o        (start),
      .stall_o        (stall_o),
      .idle_o         (idle_o),
      .ret_data_vld_o (ret_data_vld_o)
   );

   // Kernel on the single memory port
   sweep_engine u_eng (
      .clk_per          (clk_per),
      .reset_per        (reset_per),
      .start_i          (start),
      .base_addr_i      (base_addr),
      .num_threads_i    (num_threads),
      .edge_count_i     (edge_count),
      .mc_rd_rq_stall_i (mc_rd_rq_stall_i),
      .mc_wr_rq_stall_i (mc_wr_rq_stall_i),
      .mc_rsp_push_i    (mc_rsp_push_i),
      .mc_rsp_data_i    (mc_rsp_data_i),
      .idle_o           (engine_idle),
      .mc_req_ld_o      (mc_req_ld_o),
      .mc_req_st_o      (mc_req_st_o),
      .mc_req_vadr_o    (mc_req_vadr_o),
      .mc_req_wrd_o     (mc_req_wrd_o)
   );

endmodule

`default_nettype wire

/* hdl/sweep_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module sweep_engine (
   input  wire                             clk_per,
   input  wire                             reset_per,
   input  wire                             start_i,
   input  wire pers_mem_pkg::vadr_t        base_addr_i,
   input  wire pers_mem_pkg::thread_cnt_t  num_threads_i,
   input  wire pers_mem_pkg::edge_cnt_t    edge_count_i,
   input  wire                             mc_rd_rq_stall_i,
   input  wire                             mc_wr_rq_stall_i,
   input  wire                             mc_rsp_push_i,
   input  wire pers_mem_pkg::mem_word_t    mc_rsp_data_i,
   output logic                            idle_o,
   output logic                            mc_req_ld_o,
   output logic                            mc_req_st_o,
   output pers_mem_pkg::vadr_t             mc_req_vadr_o,
   output pers_mem_pkg::mem_word_t         mc_req_wrd_o
);

   import pers_mem_pkg::*;

   typedef enum logic [1:0] {S_IDLE, S_RUN, S_STORE} state_t;

   state_t      state_q;
   vadr_t       addr_q;
   thread_cnt_t thr_lim_q;
   thread_cnt_t inflight_q;
   edge_cnt_t   ld_left_q;
   edge_cnt_t   rsp_left_q;
   mem_word_t   sum_q;
   logic        start_ok;
   logic        ld_fire;
   logic        rsp_take;
   logic        st_fire;

   // --------------------------------------------------
   // Request and response qualifiers
   // --------------------------------------------------
   assign start_ok = start_i && (state_q == S_IDLE);

   assign ld_fire = (state_q == S_RUN) && (ld_left_q != '0) &&
                    (inflight_q < thr_lim_q) && !mc_rd_rq_stall_i;

   assign rsp_take = (state_q == S_RUN) && mc_rsp_push_i;

   assign st_fire = (state_q == S_STORE) && !mc_wr_rq_stall_i;

   // --------------------------------------------------
   // Control state
   // --------------------------------------------------
   always_ff @(posedge clk_per) begin
      if (reset_per) begin
         state_q    <= S_IDLE;
         inflight_q <= '0;
      end else begin
         case (state_q)
            S_IDLE: begin
               // Zero edges goes straight to the store
               if (start_ok)
                  state_q <= (edge_count_i == '0) ? S_STORE : S_RUN;
            end
            S_RUN: begin
               if (rsp_take && (rsp_left_q == edge_cnt_t'(1)))
                  state_q <= S_STORE;
            end
            S_STORE: begin
               if (st_fire)
                  state_q <= S_IDLE;
            end
            default: state_q <= S_IDLE;
         endcase
         inflight_q <= inflight_q + thread_cnt_t'(ld_fire) - thread_cnt_t'(rsp_take);
      end
   end

   // --------------------------------------------------
   // Address, counters and sum
   // --------------------------------------------------
   always_ff @(posedge clk_per) begin
      if (start_ok) begin
         addr_q     <= base_addr_i;
         thr_lim_q  <= (num_threads_i == '0) ? thread_cnt_t'(1) : num_threads_i;
         ld_left_q  <= edge_count_i;
         rsp_left_q <= edge_count_i;
         sum_q      <= '0;
      end else begin
         // After the last load the address points at the store slot
         if (ld_fire) begin
            addr_q    <= addr_q + vadr_t'(WORD_BYTES);
            ld_left_q <= ld_left_q - edge_cnt_t'(1);
         end
         if (rsp_take) begin
            sum_q      <= sum_q + mc_rsp_data_i;
            rsp_left_q <= rsp_left_q - edge_cnt_t'(1);
         end
      end
   end

   assign idle_o        = (state_q == S_IDLE);
   assign mc_req_ld_o   = ld_fire;
   assign mc_req_st_o   = st_fire;
   assign mc_req_vadr_o = addr_q;
   assign mc_req_wrd_o  = sum_q;

endmodule

`default_nettype wire

/* hdl/dispatch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl (
   input  wire  clk_per,
   input  wire  reset_per,
   input  wire  start_req_i,
   input  wire  engine_idle_i,
   input  wire  rd_vld_i,
   output logic start_o,
   output logic stall_o,
   output logic idle_o,
   output logic ret_data_vld_o
);

   typedef enum logic {ST_IDLE, ST_WAIT} state_t;

   state_t state_q;

   always_ff @(posedge clk_per) begin
      if (reset_per) begin
         start_o <= 1'b0;
         state_q <= ST_IDLE;
      end else begin
         start_o <= start_req_i;
         case (state_q)
            ST_IDLE: if (start_o) state_q <= ST_WAIT;
            ST_WAIT: if (engine_idle_i) state_q <= ST_IDLE;
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // Stall covers the start cycle and the pulse cycle before WAIT
   assign stall_o = (state_q != ST_IDLE) || start_req_i || start_o;
   assign idle_o  = (state_q == ST_IDLE) && !start_o;

   assign ret_data_vld_o = rd_vld_i && !stall_o;

endmodule

`default_nettype wire

/* hdl/aeg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module aeg_file #(
   parameter int AEG_COUNT = 3
) (
   input  wire                               clk_per,
   input  wire                               reset_per,
   input  wire                               aeg_wren_i,
   input  wire                               aeg_rden_i,
   input  wire pers_dispatch_pkg::aeg_idx_t  aeg_idx_i,
   input  wire pers_dispatch_pkg::aeg_word_t data_i,
   output pers_dispatch_pkg::aeg_word_t      ret_data_o,
   output logic                              rd_vld_o,
   output pers_mem_pkg::vadr_t               base_addr_o,
   output pers_mem_pkg::thread_cnt_t         num_threads_o,
   output pers_mem_pkg::edge_cnt_t           edge_count_o
);

   import pers_dispatch_pkg::*;
   import pers_mem_pkg::*;

   logic      r_wren;
   logic      r_rden;
   aeg_idx_t  r_idx;
   aeg_word_t r_data;
   aeg_word_t rd_word;
   aeg_word_t aeg_q [AEG_COUNT];

   // Access stage
   always_ff @(posedge clk_per) begin
      if (reset_per) begin
         r_wren   <= 1'b0;
         r_rden   <= 1'b0;
         rd_vld_o <= 1'b0;
      end else begin
         r_wren   <= aeg_wren_i;
         r_rden   <= aeg_rden_i;
         rd_vld_o <= r_rden;
      end
   end

   always_ff @(posedge clk_per) begin
      r_idx  <= aeg_idx_i;
      r_data <= data_i;
      for (int i = 0; i < AEG_COUNT; i++) begin
         if (r_wren && (r_idx == aeg_idx_t'(i)))
            aeg_q[i] <= r_data;
      end
      ret_data_o <= rd_word;
   end

   // Indices past the implemented slots read as zero
   always_comb begin
      rd_word = '0;
      for (int i = 0; i < AEG_COUNT; i++) begin
         if (r_idx == aeg_idx_t'(i))
            rd_word = aeg_q[i];
      end
   end

   // Kernel parameters
   assign base_addr_o   = aeg_q[AEG_BASE][$bits(vadr_t)-1:0];
   assign num_threads_o = aeg_q[AEG_THREADS][$bits(thread_cnt_t)-1:0];
   assign edge_count_o  = aeg_q[AEG_EDGES][$bits(edge_cnt_t)-1:0];

endmodule

`default_nettype wire

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
   input  wire pers_dispatch_pkg::inst_t     inst_i,
   input  wire pers_dispatch_pkg::aeg_word_t data_i,
   input  wire                               inst_vld_i,
   input  wire                               intlv_dis_i,
   output logic                              aeg_wren_o,
   output logic                              aeg_rden_o,
   output pers_dispatch_pkg::aeg_idx_t       aeg_idx_o,
   output logic                              start_req_o,
   output pers_dispatch_pkg::exc_t           exception_o
);

   import pers_dispatch_pkg::*;

   logic     caep_vld;
   logic     unimpl;
   aeg_idx_t idx;

   // --------------------------------------------------
   // Format and opcode decode
   // --------------------------------------------------
   always_comb begin
      aeg_wren_o = 1'b0;
      aeg_rden_o = 1'b0;
      caep_vld   = 1'b0;
      unimpl     = 1'b0;
      idx        = '0;
      case (inst_i.f567.fmt) inside
         // Format 4, opcode overlaps the low format bit
         5'b1101?: begin
            if (inst_i.f4.opc == OP_F4_WR_DATA) begin
               idx        = data_i[$bits(aeg_idx_t)-1:0];
               aeg_wren_o = inst_vld_i;
            end else if (inst_i.f4.opc == OP_F4_RD_DATA) begin
               idx        = data_i[$bits(aeg_idx_t)-1:0];
               aeg_rden_o = inst_vld_i;
            end else if (inst_i.f4.opc == OP_F4_RD_IMM) begin
               idx        = {6'h0, inst_i.f4.imm};
               aeg_rden_o = inst_vld_i;
            end else begin
               unimpl = inst_vld_i;
            end
         end
         // Format 5, index from the high and low fields
         5'b11100: begin
            if (inst_i.f567.opc == OP_F5_WR_A || inst_i.f567.opc == OP_F5_WR_B) begin
               idx        = {6'h0, inst_i.f567.idx_hi, inst_i.f567.idx_lo};
               aeg_wren_o = inst_vld_i;
            end else begin
               unimpl = inst_vld_i;
            end
         end
         // Format 6, index is bits 17:6
         5'b11101: begin
            if (inst_i.f567.opc == OP_F6_RD_IMM) begin
               idx        = {6'h0, inst_i.f567.idx_hi, inst_i.f567.mid};
               aeg_rden_o = inst_vld_i;
            end else begin
               unimpl = inst_vld_i;
            end
         end
         // Format 7, CAEP when bit 23 is set
         5'b11110: begin
            caep_vld = inst_vld_i & inst_i.f567.opc[5];
            unimpl   = inst_vld_i & ~inst_i.f567.opc[5];
         end
         default: begin
            unimpl = inst_vld_i;
         end
      endcase
   end

   assign aeg_idx_o = idx;

   // Only CAEP00 with interleave disabled starts the kernel
   assign start_req_o = caep_vld && (inst_i.f567.opc[4:0] == 5'd0) && intlv_dis_i;

   always_comb begin
      exception_o              = '0;
      exception_o[EXC_UNIMPL]  = unimpl;
      exception_o[EXC_BAD_IDX] = inst_vld_i && (idx >= aeg_idx_t'(AEG_IDX_LIMIT));
   end

endmodule

`default_nettype wire

/* hdl/pers_mem_pkg.sv */
`default_nettype none

package pers_mem_pkg;

   // --------------------------------------------------
   // Memory port types
   // --------------------------------------------------
   typedef logic [47:0] vadr_t;
   typedef logic [63:0] mem_word_t;

   // All requests are full 8-byte words
   localparam int WORD_BYTES = 8;

   // Kernel parameters
   typedef logic [8:0]  thread_cnt_t;
   typedef logic [31:0] edge_cnt_t;

endpackage

`default_nettype wire

/* hdl/pers_dispatch_pkg.sv */
`default_nettype none

package pers_dispatch_pkg;

   // --------------------------------------------------
   // Instruction word, two decode views
   // --------------------------------------------------

   // Format 4 with 7-bit opcode and 12-bit immediate
   typedef struct packed {
      logic [6:0]  rsvd_hi;
      logic [6:0]  opc;
      logic [11:0] imm;
      logic [5:0]  rsvd_lo;
   } inst_f4_t;

   // Formats 5, 6 and 7 with 6-bit opcode and split index
   typedef struct packed {
      logic [2:0] rsvd;
      logic [4:0] fmt;
      logic [5:0] opc;
      logic [5:0] idx_hi;
      logic [5:0] mid;
      logic [5:0] idx_lo;
   } inst_f567_t;

   typedef union packed {
      inst_f4_t   f4;
      inst_f567_t f567;
   } inst_t;

   typedef logic [17:0] aeg_idx_t;
   typedef logic [63:0] aeg_word_t;
   typedef logic [1:0]  exc_t;

   // Bit positions in exc_t
   localparam int EXC_UNIMPL  = 0;
   localparam int EXC_BAD_IDX = 1;

   // --------------------------------------------------
   // Opcodes
   // --------------------------------------------------
   localparam logic [6:0] OP_F4_WR_DATA = 7'h40;
   localparam logic [6:0] OP_F4_RD_DATA = 7'h68;
   localparam logic [6:0] OP_F4_RD_IMM  = 7'h70;
   localparam logic [5:0] OP_F5_WR_A    = 6'h18;
   localparam logic [5:0] OP_F5_WR_B    = 6'h20;
   localparam logic [5:0] OP_F6_RD_IMM  = 6'h1C;

   localparam int AEG_IDX_LIMIT = 256;

   // Kernel parameter slots
   localparam int AEG_BASE    = 0;
   localparam int AEG_THREADS = 1;
   localparam int AEG_EDGES   = 2;

endpackage

`default_nettype wire
